/* rtl/cache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl #(
    parameter int SETS = 4
) (
    input logic clk,
    input logic proc_reset,
    input logic proc_read,
    input logic proc_write,
    input cache_geom_pkg::proc_addr_t proc_addr,
    output logic proc_stall,
    output logic mem_read,
    output logic mem_write,
    output cache_geom_pkg::mem_addr_t mem_addr,
    input logic mem_ready,
    cache_lookup_if.ctrl lookup
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = cache_geom_pkg::MEM_ADDR_W - IDX_W;

    cache_ctrl_pkg::cache_state_t state;
    cache_ctrl_pkg::cache_state_t state_next;
    cache_ctrl_pkg::way_t alloc_way;

    logic request;
    logic [IDX_W-1:0] req_index;
    logic [TAG_W-1:0] req_tag;

    assign request = proc_read || proc_write;
    assign req_index = proc_addr[cache_geom_pkg::OFFSET_W +: IDX_W];
    assign req_tag = proc_addr[cache_geom_pkg::PROC_ADDR_W-1 -: TAG_W];

    // hit way while looking up, victim way for the whole miss
    assign lookup.way = (state == cache_ctrl_pkg::ST_IDLE) ? lookup.hit_way : alloc_way;

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= cache_ctrl_pkg::ST_IDLE;
            alloc_way <= 1'b0;
        end else begin
            state <= state_next;
            if (state == cache_ctrl_pkg::ST_IDLE && request && !lookup.hit) begin
                alloc_way <= lookup.victim_way;
            end
        end
    end

    always_comb begin
        state_next = state;
        proc_stall = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_addr = {req_tag, req_index};
        lookup.touch = 1'b0;
        lookup.word_write = 1'b0;
        lookup.fill = 1'b0;
        case (state)
            cache_ctrl_pkg::ST_IDLE: begin
                if (request && lookup.hit) begin
                    lookup.touch = 1'b1;
                    lookup.word_write = proc_write;
                end else if (request) begin
                    proc_stall = 1'b1;
                    if (lookup.victim_dirty) begin
                        state_next = cache_ctrl_pkg::ST_WRITE_BACK;
                    end else begin
                        // clean or empty victim, fetch right away
                        mem_read = 1'b1;
                        state_next = cache_ctrl_pkg::ST_ALLOCATE;
                    end
                end
            end
            cache_ctrl_pkg::ST_WRITE_BACK: begin
                proc_stall = 1'b1;
                if (mem_ready) begin
                    mem_read = 1'b1;
                    state_next = cache_ctrl_pkg::ST_ALLOCATE;
                end else begin
                    mem_write = 1'b1;
                    mem_addr = {lookup.line_tag, req_index};
                end
            end
            cache_ctrl_pkg::ST_ALLOCATE: begin
                proc_stall = 1'b1;
                mem_read = 1'b1;
                if (mem_ready) begin
                    lookup.fill = 1'b1;
                    if (proc_write) begin
                        // write miss finishes on the fill edge
                        lookup.word_write = 1'b1;
                        proc_stall = 1'b0;
                        state_next = cache_ctrl_pkg::ST_IDLE;
                    end else begin
                        state_next = cache_ctrl_pkg::ST_OUTPUT;
                    end
                end
            end
            cache_ctrl_pkg::ST_OUTPUT: begin
                // word comes from the freshly filled line
                state_next = cache_ctrl_pkg::ST_IDLE;
            end
            default: begin
                state_next = cache_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    // miss handling sequence of the controller
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0,
        ST_WRITE_BACK = 2'd1,
        ST_ALLOCATE   = 2'd2,
        ST_OUTPUT     = 2'd3
    } cache_state_t;

    // two ways only, one bit is enough
    typedef logic way_t;

endpackage

`default_nettype wire

/* rtl/cache_data_array.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_data_array #(
    parameter int SETS = 4
) (
    input logic clk,
    input cache_geom_pkg::proc_addr_t proc_addr,
    input cache_geom_pkg::word_t proc_wdata,
    input cache_geom_pkg::line_t mem_rdata,
    output cache_geom_pkg::word_t proc_rdata,
    output cache_geom_pkg::line_t mem_wdata,
    cache_lookup_if.data lookup
);

    localparam int IDX_W = $clog2(SETS);

    cache_geom_pkg::line_t lines [SETS][2];

    logic [IDX_W-1:0] req_index;
    logic [cache_geom_pkg::OFFSET_W-1:0] req_offset;
    cache_geom_pkg::line_t cur_line;
    cache_geom_pkg::line_t next_line;

    assign req_index = proc_addr[cache_geom_pkg::OFFSET_W +: IDX_W];
    assign req_offset = proc_addr[cache_geom_pkg::OFFSET_W-1:0];

    assign cur_line = lines[req_index][lookup.way];

    // word select for the processor
    assign proc_rdata = cur_line[req_offset * cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];

    // whole line goes out on write-back
    assign mem_wdata = cur_line;

    // incoming line or current line, with the new word merged on a write
    always_comb begin
        if (lookup.fill) begin
            next_line = mem_rdata;
        end else begin
            next_line = cur_line;
        end
        if (lookup.word_write) begin
            next_line[req_offset * cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] = proc_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.fill || lookup.word_write) begin
            lines[req_index][lookup.way] <= next_line;
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    // processor side
    parameter int WORD_W = 32;
    parameter int PROC_ADDR_W = 30;

    // line layout, four words per line
    parameter int WORDS_PER_LINE = 4;
    parameter int OFFSET_W = 2;
    parameter int LINE_W = WORD_W * WORDS_PER_LINE;

    // memory side works on whole lines
    parameter int MEM_ADDR_W = PROC_ADDR_W - OFFSET_W;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic [LINE_W-1:0] line_t;

    typedef logic [PROC_ADDR_W-1:0] proc_addr_t;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* rtl/cache_lookup_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cache_lookup_if #(
    parameter int SETS = 4
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = cache_geom_pkg::MEM_ADDR_W - IDX_W;

    // lookup results from the tag array
    logic hit;
    cache_ctrl_pkg::way_t hit_way;
    cache_ctrl_pkg::way_t victim_way;
    logic victim_dirty;
    logic [TAG_W-1:0] line_tag;

    // way select and update strobes from the controller
    cache_ctrl_pkg::way_t way;
    logic touch;
    logic word_write;
    logic fill;

    modport tags (
        output hit, hit_way, victim_way, victim_dirty, line_tag,
        input way, touch, word_write, fill
    );

    modport data (
        input way, word_write, fill
    );

    modport ctrl (
        input hit, hit_way, victim_way, victim_dirty, line_tag,
        output way, touch, word_write, fill
    );

endinterface

`default_nettype wire

/* rtl/cache_tag_array.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_tag_array #(
    parameter int SETS = 4
) (
    input logic clk,
    input logic proc_reset,
    input cache_geom_pkg::proc_addr_t proc_addr,
    cache_lookup_if.tags lookup
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = cache_geom_pkg::MEM_ADDR_W - IDX_W;

    logic [TAG_W-1:0] tags [SETS][2];
    logic [1:0] valid [SETS];
    logic [1:0] dirty [SETS];
    // lru bit names the way to replace next
    logic [SETS-1:0] lru;

    logic [IDX_W-1:0] req_index;
    logic [TAG_W-1:0] req_tag;
    logic way0_hit;
    logic way1_hit;
    cache_ctrl_pkg::way_t victim;

    assign req_index = proc_addr[cache_geom_pkg::OFFSET_W +: IDX_W];
    assign req_tag = proc_addr[cache_geom_pkg::PROC_ADDR_W-1 -: TAG_W];

    // compare against both ways of the set
    assign way0_hit = valid[req_index][0] && (tags[req_index][0] == req_tag);
    assign way1_hit = valid[req_index][1] && (tags[req_index][1] == req_tag);

    assign lookup.hit = way0_hit || way1_hit;
    assign lookup.hit_way = way0_hit ? 1'b0 : 1'b1;

    // empty ways are filled before anything is evicted
    always_comb begin
        if (!valid[req_index][0]) begin
            victim = 1'b0;
        end else if (!valid[req_index][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru[req_index];
        end
    end

    assign lookup.victim_way = victim;
    assign lookup.victim_dirty = valid[req_index][victim] && dirty[req_index][victim];
    assign lookup.line_tag = tags[req_index][lookup.way];

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= 2'b00;
                dirty[s] <= 2'b00;
            end
            lru <= '0;
        end else begin
            if (lookup.touch) begin
                lru[req_index] <= ~lookup.way;
            end
            if (lookup.fill) begin
                valid[req_index][lookup.way] <= 1'b1;
                dirty[req_index][lookup.way] <= 1'b0;
                lru[req_index] <= ~lookup.way;
            end
            // a write miss fills and writes together, dirty wins
            if (lookup.word_write) begin
                dirty[req_index][lookup.way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.fill) begin
            tags[req_index][lookup.way] <= req_tag;
        end
    end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
    parameter int SETS = 4
) (
    input logic clk,
    input logic proc_reset,
    input logic proc_read,
    input logic proc_write,
    input cache_geom_pkg::proc_addr_t proc_addr,
    input cache_geom_pkg::word_t proc_wdata,
    output logic proc_stall,
    output cache_geom_pkg::word_t proc_rdata,
    output logic mem_read,
    output logic mem_write,
    output cache_geom_pkg::mem_addr_t mem_addr,
    output cache_geom_pkg::line_t mem_wdata,
    input cache_geom_pkg::line_t mem_rdata,
    input logic mem_ready
);

    cache_lookup_if #(.SETS(SETS)) lookup ();

    cache_tag_array #(.SETS(SETS)) u_tag_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_addr  (proc_addr),
        .lookup     (lookup.tags)
    );

    cache_data_array #(.SETS(SETS)) u_data_array (
        .clk        (clk),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .mem_rdata  (mem_rdata),
        .proc_rdata (proc_rdata),
        .mem_wdata  (mem_wdata),
        .lookup     (lookup.data)
    );

    cache_ctrl #(.SETS(SETS)) u_ctrl (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_stall (proc_stall),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .lookup     (lookup.ctrl)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the cache testbench with Verilator, run it, then search the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cache_tb -f tb.f -o cache_sim &&
    obj_dir/cache_sim | tee sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

/* tb.f */
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_lookup_if.sv
rtl/cache_tag_array.sv
rtl/cache_data_array.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verification/cache_sva.sv
verification/cache_tb.sv

/* verification/cache_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_sva (
    input logic clk,
    input logic proc_reset,
    input logic proc_write,
    input logic proc_stall,
    input logic mem_read,
    input logic mem_write,
    input cache_geom_pkg::mem_addr_t mem_addr,
    input logic mem_ready
);

    // one transfer direction at a time
    mem_excl: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // address holds until the memory answers
    read_addr_hold: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read && !mem_ready) |=> $stable(mem_addr))
        else $error("mem_addr changed during a pending line read");

    write_addr_hold: assert property (@(posedge clk) disable iff (proc_reset)
        (mem_write && !mem_ready) |=> (mem_ready || (mem_write && $stable(mem_addr))))
        else $error("mem_addr or mem_write changed during a pending write-back");

    // only a write miss may release the processor while memory is busy
    stall_on_request: assert property (@(posedge clk) disable iff (proc_reset)
        ((mem_read || mem_write) && !(mem_ready && proc_write)) |-> proc_stall)
        else $error("proc_stall low during a memory request");

endmodule

bind cache_top cache_sva u_sva (
    .clk        (clk),
    .proc_reset (proc_reset),
    .proc_write (proc_write),
    .proc_stall (proc_stall),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready)
);

`default_nettype wire

/* verification/cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int SETS = 4;
    localparam int ACCESSES = 400;
    localparam int ACCESS_TIMEOUT = 24;
    // three tags per set so that lines conflict
    localparam logic [25:0] TAG_POOL [3] = '{26'h0000013, 26'h15a5a5a, 26'h2c3c3c3};

    logic clk;
    logic proc_reset;
    logic proc_read;
    logic proc_write;
    cache_geom_pkg::proc_addr_t proc_addr;
    cache_geom_pkg::word_t proc_wdata;
    logic proc_stall;
    cache_geom_pkg::word_t proc_rdata;
    logic mem_read;
    logic mem_write;
    cache_geom_pkg::mem_addr_t mem_addr;
    cache_geom_pkg::line_t mem_wdata;
    cache_geom_pkg::line_t mem_rdata;
    logic mem_ready;

    // written-back lines, and the last value the processor wrote per word
    cache_geom_pkg::line_t mem_lines [cache_geom_pkg::mem_addr_t];
    cache_geom_pkg::word_t words [cache_geom_pkg::proc_addr_t];

    // tag state model of the cache
    logic [25:0] m_tag [SETS][2];
    logic [1:0] m_valid [SETS];
    logic [1:0] m_dirty [SETS];
    logic [SETS-1:0] m_lru;
    logic [15:0] lfsr;
    int acc_num;

    cache_top #(.SETS(SETS)) dut (.*);

    always #2 clk = ~clk;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // power-up memory contents depend on every address bit
    function automatic cache_geom_pkg::word_t init_word(input cache_geom_pkg::proc_addr_t a);
        return {a, 2'b10} ^ 32'h9e3779b9;
    endfunction

    function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::proc_addr_t a);
        if (words.exists(a)) begin
            return words[a];
        end
        return init_word(a);
    endfunction

    // memory's view of a line, or the line as the flat word model sees it
    function automatic cache_geom_pkg::line_t line_of(input cache_geom_pkg::mem_addr_t la,
                                                      input logic from_memory);
        cache_geom_pkg::line_t l;
        if (from_memory && mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = from_memory ? init_word({la, 2'(w)}) : expected_word({la, 2'(w)});
        end
        return l;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act) else begin
            stop_on_error($sformatf("MISMATCH %s access %0d expected %0h actual %0h",
                name, acc_num, exp, act));
        end
    endtask

    // one processor access from the request cycle until proc_stall drops
    task automatic do_access(input logic is_write, input cache_geom_pkg::proc_addr_t a,
                             input cache_geom_pkg::word_t wd);
        logic [1:0] idx;
        logic [25:0] tg;
        logic hit;
        logic way;
        logic vdirty;
        logic seen;
        logic done;
        logic [31:0] r;
        int phase;
        int wait_left;
        int cycles;
        cache_geom_pkg::mem_addr_t victim_addr;
        idx = a[3:2];
        tg = a[29:4];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        if (!hit) begin
            way = !m_valid[idx][0] ? 1'b0 : (!m_valid[idx][1] ? 1'b1 : m_lru[idx]);
        end
        vdirty = !hit && m_valid[idx][way] && m_dirty[idx][way];
        victim_addr = {m_tag[idx][way], idx};
        proc_read = !is_write;
        proc_write = is_write;
        proc_addr = a;
        proc_wdata = wd;
        mem_ready = 1'b0;
        // 0 request, 1 write-back, 2 fetch, 3 output
        phase = 0;
        cycles = 0;
        wait_left = 0;
        done = 1'b0;
        while (!done) begin
            #1;
            seen = 1'b0;
            case (phase)
                0: begin
                    if (hit) begin
                        check_val("hit ctrl", 128'(3'b000), 128'({proc_stall, mem_read, mem_write}));
                        if (!is_write) begin
                            check_val("hit rdata", 128'(expected_word(a)), 128'(proc_rdata));
                        end
                    end else begin
                        check_val("miss ctrl", 128'({1'b1, !vdirty, 1'b0}),
                                  128'({proc_stall, mem_read, mem_write}));
                        if (!vdirty) begin
                            check_val("miss addr", 128'(a[29:2]), 128'(mem_addr));
                        end
                        take_bits(2, r);
                        wait_left = int'(r[1:0]);
                        seen = !vdirty;
                        phase = vdirty ? 1 : 2;
                    end
                end
                1: begin
                    if (!mem_ready) begin
                        check_val("wb ctrl", 128'(3'b101), 128'({proc_stall, mem_read, mem_write}));
                        check_val("wb addr", 128'(victim_addr), 128'(mem_addr));
                        check_val("wb data", line_of(victim_addr, 1'b0), mem_wdata);
                        seen = 1'b1;
                    end else begin
                        check_val("wb done ctrl", 128'(3'b110),
                                  128'({proc_stall, mem_read, mem_write}));
                        check_val("wb done addr", 128'(a[29:2]), 128'(mem_addr));
                        mem_lines[victim_addr] = mem_wdata;
                        take_bits(2, r);
                        wait_left = int'(r[1:0]);
                        phase = 2;
                    end
                end
                2: begin
                    check_val("fetch addr", 128'(a[29:2]), 128'(mem_addr));
                    if (!mem_ready || !is_write) begin
                        check_val("fetch ctrl", 128'(3'b110), 128'({proc_stall, mem_read, mem_write}));
                        seen = !mem_ready;
                        phase = mem_ready ? 3 : 2;
                    end else begin
                        check_val("write miss ctrl", 128'(3'b010),
                                  128'({proc_stall, mem_read, mem_write}));
                    end
                end
                default: begin
                    check_val("output ctrl", 128'(3'b000), 128'({proc_stall, mem_read, mem_write}));
                    check_val("output rdata", 128'(expected_word(a)), 128'(proc_rdata));
                end
            endcase
            done = !proc_stall;
            cycles++;
            assert (done || cycles < ACCESS_TIMEOUT) else begin
                stop_on_error($sformatf("access %0d did not finish within %0d cycles",
                    acc_num, ACCESS_TIMEOUT));
            end
            if (!done) begin
                @(negedge clk);
                // memory answers once the request was seen and its wait ran out
                mem_ready = 1'b0;
                if (seen && wait_left == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = line_of(a[29:2], 1'b1);
                end else if (seen) begin
                    wait_left--;
                end
            end
        end
        if (!hit) begin
            m_tag[idx][way] = tg;
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
        end
        m_lru[idx] = ~way;
        if (is_write) begin
            m_dirty[idx][way] = 1'b1;
            words[a] = wd;
        end
    endtask

    initial begin
        #100000;
        stop_on_error("simulation ran past its time limit");
    end

    initial begin
        logic [31:0] r;
        logic wr;
        cache_geom_pkg::proc_addr_t a;
        cache_geom_pkg::word_t wd;
        clk = 1'b0;
        proc_reset = 1'b1;
        proc_read = 1'b0;
        proc_write = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        lfsr = 16'd35390;
        acc_num = 0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = 2'b00;
            m_dirty[s] = 2'b00;
        end
        m_lru = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        proc_reset = 1'b0;
        #1;
        check_val("reset ctrl", 128'(3'b000), 128'({proc_stall, mem_read, mem_write}));
        for (int n = 0; n < ACCESSES; n++) begin
            acc_num = n;
            take_bits(2, r);
            a[29:4] = TAG_POOL[int'(r % 3)];
            take_bits(4, r);
            a[3:0] = r[3:0];
            take_bits(1, r);
            wr = r[0];
            take_bits(32, wd);
            @(negedge clk);
            do_access(wr, a, wd);
        end
        @(negedge clk);
        proc_read = 1'b0;
        proc_write = 1'b0;
        mem_ready = 1'b0;
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
